//--- src/wall_pkg.sv
// field bounds, list sizes, luck thresholds, cell and list types, luck mode enum
`default_nettype none

package wall_pkg;

    //////////////////////////////////////////////////////////////////////
    // playfield
    //////////////////////////////////////////////////////////////////////

    // one coordinate, 16 cells per axis
    localparam int coord_w = 4;

    // walls only go strictly inside these
    localparam logic [coord_w-1:0] x_min = 4'd0;
    localparam logic [coord_w-1:0] x_max = 4'd15;
    localparam logic [coord_w-1:0] y_min = 4'd0;
    localparam logic [coord_w-1:0] y_max = 4'd15;

    // y on top, x below, same packing as the random source
    typedef struct packed {
        logic [coord_w-1:0] y;
        logic [coord_w-1:0] x;
    } cell_t;

    //////////////////////////////////////////////////////////////////////
    // lists and timing
    //////////////////////////////////////////////////////////////////////

    localparam int max_walls   = 25;
    localparam int snake_len   = 30;
    localparam int wall_cnt_w  = 5;
    // cycles from the scheduling pulse to spawn_req
    localparam int spawn_delay = 30;
    localparam int delay_cnt_w = $clog2(spawn_delay);

    typedef cell_t [snake_len-1:0] body_t;
    typedef cell_t [max_walls-1:0] wall_arr_t;

    //////////////////////////////////////////////////////////////////////
    // luck filter
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        luck_normal  = 2'd0,
        luck_unlucky = 2'd1,
        luck_lucky   = 2'd2
    } luck_mode_t;

    localparam int luck_cnt_w = 8;

    // manhattan distances from the head
    localparam int far_dist     = 8;
    localparam int far_relaxed  = 6;
    localparam int near_dist    = 3;
    localparam int near_relaxed = 5;
    // refusals before the rule loosens, then before anything valid goes
    localparam int relax_count  = 50;
    localparam int force_count  = 90;

endpackage

`default_nettype wire

//--- src/spawn_trigger.sv
// spawn_trigger: collision pairing, scheduled-wall cap and release delay
`default_nettype none

module spawn_trigger (
    input  logic system_clk,
    input  logic nreset,
    input  logic good_collision,
    input  logic wall_added,
    output logic spawn_req
);

    // high after an odd number of good collisions
    logic                               pair_q;
    // walls scheduled so far, caps at max_walls
    logic [wall_pkg::wall_cnt_w-1:0]    sched_cnt;
    logic [wall_pkg::delay_cnt_w-1:0]   delay_cnt;
    // delay running, request not yet raised
    logic                               pending;
    logic                               schedule;

    // second collision of a pair, only while under the cap
    assign schedule = good_collision & pair_q & (sched_cnt < wall_pkg::max_walls);

    //////////////////////////////////////////////////////////////////////
    // pairing and cap
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge system_clk, negedge nreset) begin
        if (!nreset) begin
            pair_q    <= 1'b0;
            sched_cnt <= '0;
        end else begin
            if (good_collision) begin
                pair_q <= ~pair_q;
            end
            // counts even when merged into an open request
            if (schedule) begin
                sched_cnt <= sched_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // release delay and request level
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge system_clk, negedge nreset) begin
        if (!nreset) begin
            pending   <= 1'b0;
            delay_cnt <= '0;
            spawn_req <= 1'b0;
        end else begin
            // request ends with the accepted wall
            if (wall_added) begin
                spawn_req <= 1'b0;
            end
            // new schedule only when idle, otherwise merged
            if (schedule && !pending && !spawn_req) begin
                pending   <= 1'b1;
                delay_cnt <= 1'b1;
            end else if (pending) begin
                // cycle spawn_delay-1 after the pulse, raise on this edge
                if (delay_cnt == wall_pkg::spawn_delay - 1) begin
                    pending   <= 1'b0;
                    delay_cnt <= '0;
                    spawn_req <= 1'b1;
                end else begin
                    delay_cnt <= delay_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/cell_match.sv
// cell_match: compares one cell against every entry of a cell array
`default_nettype none

module cell_match #(
    parameter type entry_t   = wall_pkg::body_t,
    parameter int  n_entries = wall_pkg::snake_len
) (
    input  wall_pkg::cell_t probe,
    input  entry_t          entries,
    output logic            hit
);

    // one flag per entry
    logic [n_entries-1:0] match_vec;

    always_comb begin
        for (int i = 0; i < n_entries; i++) begin
            // whole cell compare, x and y together
            match_vec[i] = (entries[i] == probe);
        end
    end

    // any entry equal to the probe
    assign hit = |match_vec;

endmodule

`default_nettype wire

//--- src/candidate_check.sv
// candidate_check: validity and luck tests per random cell, luck counter, accept pulse
`default_nettype none

module candidate_check (
    input  logic                   system_clk,
    input  logic                   nreset,
    input  logic                   spawn_req,
    input  wall_pkg::luck_mode_t   luck_mode,
    input  wall_pkg::cell_t        rand_cell,
    input  wall_pkg::cell_t        snake_head,
    input  logic                   body_hit,
    input  logic                   wall_hit,
    output logic                   wall_added,
    output wall_pkg::cell_t        new_wall
);

    logic                               searching;
    logic                               in_bounds;
    logic                               valid;
    logic                               luck_ok;
    logic                               accept;
    logic [wall_pkg::coord_w-1:0]       dx;
    logic [wall_pkg::coord_w-1:0]       dy;
    // up to 30, one bit wider than a coordinate
    logic [wall_pkg::coord_w:0]         head_dist;
    logic [wall_pkg::luck_cnt_w-1:0]    luck_cnt;

    // spawn_req is still high during the wall_added cycle
    assign searching = spawn_req & ~wall_added;

    //////////////////////////////////////////////////////////////////////
    // validity
    //////////////////////////////////////////////////////////////////////

    // bounds are exclusive
    assign in_bounds = (rand_cell.x > wall_pkg::x_min) && (rand_cell.x < wall_pkg::x_max) &&
                       (rand_cell.y > wall_pkg::y_min) && (rand_cell.y < wall_pkg::y_max);

    assign valid = in_bounds && (rand_cell != snake_head) && !body_hit && !wall_hit;

    //////////////////////////////////////////////////////////////////////
    // luck rule
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // manhattan distance to the head
        dx        = (rand_cell.x >= snake_head.x) ? rand_cell.x - snake_head.x
                                                  : snake_head.x - rand_cell.x;
        dy        = (rand_cell.y >= snake_head.y) ? rand_cell.y - snake_head.y
                                                  : snake_head.y - rand_cell.y;
        head_dist = {1'b0, dx} + {1'b0, dy};

        case (luck_mode)
            wall_pkg::luck_unlucky: begin
                // far away, loosened after many refusals
                luck_ok = (head_dist >= wall_pkg::far_dist) ||
                          ((head_dist >= wall_pkg::far_relaxed) &&
                           (luck_cnt > wall_pkg::relax_count)) ||
                          (luck_cnt >= wall_pkg::force_count);
            end
            wall_pkg::luck_lucky: begin
                // close to the head
                luck_ok = (head_dist <= wall_pkg::near_dist) ||
                          ((head_dist <= wall_pkg::near_relaxed) &&
                           (luck_cnt >= wall_pkg::relax_count)) ||
                          (luck_cnt >= wall_pkg::force_count);
            end
            default: begin
                luck_ok = 1'b1;
            end
        endcase
    end

    assign accept = searching & valid & luck_ok;

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge system_clk, negedge nreset) begin
        if (!nreset) begin
            wall_added <= 1'b0;
            luck_cnt   <= '0;
        end else begin
            wall_added <= accept;
            // only valid cells touch the counter, kept across searches
            if (searching && valid) begin
                if (luck_ok) begin
                    luck_cnt <= '0;
                end else begin
                    luck_cnt <= luck_cnt + 1'b1;
                end
            end
        end
    end

    // accepted cell, read only with wall_added
    always_ff @(posedge system_clk) begin
        if (accept) begin
            new_wall <= rand_cell;
        end
    end

endmodule

`default_nettype wire

//--- src/wall_list.sv
// wall_list: shift register of placed walls and saturating wall count
`default_nettype none

module wall_list (
    input  logic                            system_clk,
    input  logic                            nreset,
    input  logic                            wall_added,
    input  wall_pkg::cell_t                 new_wall,
    output wall_pkg::wall_arr_t             walls,
    output logic [wall_pkg::wall_cnt_w-1:0] wall_count
);

    wall_pkg::wall_arr_t                list_q;
    wall_pkg::wall_arr_t                list_shift;
    logic [wall_pkg::wall_cnt_w-1:0]    cnt_q;
    logic [wall_pkg::wall_cnt_w-1:0]    cnt_next;

    // newest in slot 0, oldest falls off the top
    assign list_shift = {list_q[wall_pkg::max_walls-2:0], new_wall};
    assign cnt_next   = (cnt_q < wall_pkg::max_walls) ? cnt_q + 1'b1 : cnt_q;

    // the shifted list shows from the edge that raises wall_added
    assign walls      = wall_added ? list_shift : list_q;
    assign wall_count = wall_added ? cnt_next : cnt_q;

    always_ff @(posedge system_clk, negedge nreset) begin
        if (!nreset) begin
            list_q <= '0;
            cnt_q  <= '0;
        end else if (wall_added) begin
            list_q <= list_shift;
            cnt_q  <= cnt_next;
        end
    end

endmodule

`default_nettype wire

//--- src/wall_spawner.sv
// wall_spawner: top level with trigger, candidate checker, body and wall matchers, wall list
`default_nettype none

module wall_spawner (
    input  logic                            system_clk,
    input  logic                            nreset,
    input  logic                            good_collision,
    input  wall_pkg::luck_mode_t            luck_mode,
    input  wall_pkg::cell_t                 snake_head,
    input  wall_pkg::body_t                 snake_body,
    // one fresh random cell per clock
    input  wall_pkg::cell_t                 rand_cell,
    output wall_pkg::wall_arr_t             walls,
    output logic [wall_pkg::wall_cnt_w-1:0] wall_count,
    output logic                            wall_added
);

    logic               spawn_req;
    logic               body_hit;
    logic               wall_hit;
    wall_pkg::cell_t    new_wall;

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////

    spawn_trigger trigger (
        .system_clk     (system_clk),
        .nreset         (nreset),
        .good_collision (good_collision),
        .wall_added     (wall_added),
        .spawn_req      (spawn_req)
    );

    // random cell against the snake body
    cell_match #(
        .entry_t   (wall_pkg::body_t),
        .n_entries (wall_pkg::snake_len)
    ) body_match (
        .probe   (rand_cell),
        .entries (snake_body),
        .hit     (body_hit)
    );

    // and against the walls already placed
    cell_match #(
        .entry_t   (wall_pkg::wall_arr_t),
        .n_entries (wall_pkg::max_walls)
    ) wall_match (
        .probe   (rand_cell),
        .entries (walls),
        .hit     (wall_hit)
    );

    //////////////////////////////////////////////////////////////////////
    // search and result
    //////////////////////////////////////////////////////////////////////

    candidate_check cand_check (
        .system_clk (system_clk),
        .nreset     (nreset),
        .spawn_req  (spawn_req),
        .luck_mode  (luck_mode),
        .rand_cell  (rand_cell),
        .snake_head (snake_head),
        .body_hit   (body_hit),
        .wall_hit   (wall_hit),
        .wall_added (wall_added),
        .new_wall   (new_wall)
    );

    wall_list list (
        .system_clk (system_clk),
        .nreset     (nreset),
        .wall_added (wall_added),
        .new_wall   (new_wall),
        .walls      (walls),
        .wall_count (wall_count)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// testbench clock of 100 ns period and active-low reset held for two rising edges
`default_nettype none

module tb_clock_gen (
    output logic system_clk,
    output logic nreset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 50;

    initial begin
        system_clk = 1'b0;
        forever #half_period system_clk = ~system_clk;
    end

    // low across the first two rising edges
    initial begin
        nreset = 1'b0;
        repeat (2) @(posedge system_clk);
        nreset <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/wall_spawner_tb.sv
// wall_spawner_tb: data file reader, stimulus tasks, wall list model, accept monitor, watchdog
`default_nettype none

module wall_spawner_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // corner cell, always on the bounds
    localparam wall_pkg::cell_t filler = 8'h00;
    localparam int cycles_per_line = 200;
    // longest search the data file asks for
    localparam int accept_limit    = 200;

    logic                            system_clk;
    logic                            nreset;
    logic                            good_collision;
    wall_pkg::luck_mode_t            luck_mode;
    wall_pkg::cell_t                 snake_head;
    wall_pkg::body_t                 snake_body;
    wall_pkg::cell_t                 rand_cell;
    wall_pkg::wall_arr_t             walls;
    logic [wall_pkg::wall_cnt_w-1:0] wall_count;
    logic                            wall_added;

    // expected list, newest in slot 0
    wall_pkg::wall_arr_t             model_walls;
    int                              model_count;
    int                              cycle = 0;
    int                              last_collide;
    // edges from the last collision drive to the latest wall_added
    int                              accept_latency;
    int                              watch_cycles = 0;

    // one entry per wall_added pulse
    wall_pkg::wall_arr_t             ev_walls[$];
    logic [wall_pkg::wall_cnt_w-1:0] ev_count[$];
    int                              ev_cycle[$];

    tb_clock_gen clocks (
        .system_clk (system_clk),
        .nreset     (nreset)
    );

    wall_spawner UUT (
        .system_clk     (system_clk),
        .nreset         (nreset),
        .good_collision (good_collision),
        .luck_mode      (luck_mode),
        .snake_head     (snake_head),
        .snake_body     (snake_body),
        .rand_cell      (rand_cell),
        .walls          (walls),
        .wall_count     (wall_count),
        .wall_added     (wall_added)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [199:0] actual,
                               input logic [199:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, actual, expected);
            abort_run("value check failed");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic set_snake(input int mode, input wall_pkg::cell_t head,
                             input wall_pkg::body_t body);
        @(posedge system_clk);
        luck_mode  <= wall_pkg::luck_mode_t'(mode[1:0]);
        snake_head <= head;
        snake_body <= body;
    endtask

    task automatic pulse_collision();
        @(posedge system_clk);
        good_collision <= 1'b1;
        last_collide = cycle;
        @(posedge system_clk);
        good_collision <= 1'b0;
    endtask

    task automatic drive_cell(input wall_pkg::cell_t c);
        @(posedge system_clk);
        rand_cell <= c;
    endtask

    // holds one cell, no wall may appear meanwhile
    task automatic drive_idle(input int n, input wall_pkg::cell_t c);
        repeat (n) begin
            @(posedge system_clk);
            rand_cell <= c;
            @(negedge system_clk);
            check_value("wall_added", wall_added, 1'b0);
        end
    endtask

    // next accepted wall against the model list
    task automatic expect_wall(input wall_pkg::cell_t exp_cell, input int count);
        int                              waited;
        int                              got_cycle;
        int                              s;
        wall_pkg::wall_arr_t             got_walls;
        logic [wall_pkg::wall_cnt_w-1:0] got_count;
        waited = 0;
        while (ev_walls.size() == 0 && waited < accept_limit) begin
            @(posedge system_clk);
            rand_cell <= filler;
            waited++;
        end
        if (ev_walls.size() == 0) begin
            abort_run("no wall was placed within the search window");
        end else begin
            got_walls = ev_walls.pop_front();
            got_count = ev_count.pop_front();
            got_cycle = ev_cycle.pop_front();
            // older walls move up one slot, oldest is lost
            for (s = wall_pkg::max_walls - 1; s > 0; s--) begin
                model_walls[s] = model_walls[s-1];
            end
            model_walls[0] = exp_cell;
            model_count++;
            // edges from the collision drive to wall_added
            accept_latency = got_cycle - 1 - last_collide;
            check_value("walls[0]", got_walls[0], exp_cell);
            check_value("walls", got_walls, model_walls);
            check_value("wall_count", got_count, count);
        end
    endtask

    // row by row from x = 1, one pair per wall
    task automatic fill_walls(input int n, input int row);
        int              i;
        int              exp_count;
        wall_pkg::cell_t c;
        for (i = 0; i < n; i++) begin
            c.x = 1 + i % 13;
            c.y = row + i / 13;
            pulse_collision();
            pulse_collision();
            // valid cell already on offer while the delay runs
            drive_idle(wall_pkg::spawn_delay - 1, c);
            exp_count = model_count + 1;
            expect_wall(c, exp_count);
            check_value("wall_added latency", accept_latency, wall_pkg::spawn_delay + 1);
        end
    endtask

    // pairs past the cap with a valid cell on offer
    task automatic extra_pairs(input int n, input wall_pkg::cell_t c);
        repeat (n) begin
            pulse_collision();
            drive_idle(4, c);
            pulse_collision();
            drive_idle(wall_pkg::spawn_delay + 10, c);
        end
    endtask

    task automatic check_count(input int n);
        @(negedge system_clk);
        check_value("wall_count", wall_count, n);
    endtask

    //////////////////////////////////////////////////////////////////////
    // accept monitor and watchdog
    //////////////////////////////////////////////////////////////////////

    always @(negedge system_clk) begin
        cycle = cycle + 1;
        if (nreset && wall_added) begin
            ev_walls.push_back(walls);
            ev_count.push_back(wall_count);
            ev_cycle.push_back(cycle);
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge system_clk);
        abort_run("timeout: the test data did not finish within the watchdog limit");
    end

    //////////////////////////////////////////////////////////////////////
    // command loop
    //////////////////////////////////////////////////////////////////////

    initial begin
        int              fd;
        int              r;
        int              i;
        int              n_lines;
        int              mode_v;
        int              n_v;
        int              m_v;
        logic [7:0]      cell_v;
        logic [7:0]      seg_v;
        logic [127:0]    cmd;
        logic [2047:0]   line_buf;
        wall_pkg::body_t body_v;
        logic            done;

        good_collision = 1'b0;
        luck_mode      = wall_pkg::luck_normal;
        snake_head     = '0;
        snake_body     = '0;
        rand_cell      = filler;
        model_walls    = '0;
        model_count    = 0;
        last_collide   = 0;
        accept_latency = 0;

        // first pass sizes the watchdog
        fd = $fopen("verif/wall_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test data file verif/wall_testdata.txt");
        end
        n_lines = 0;
        while ($fgets(line_buf, fd) != 0) begin
            n_lines++;
        end
        $fclose(fd);
        watch_cycles = n_lines * cycles_per_line;
        fd = $fopen("verif/wall_testdata.txt", "r");

        // state straight out of reset
        while (nreset !== 1'b1) @(posedge system_clk);
        @(negedge system_clk);
        check_value("walls", walls, '0);
        check_value("wall_count", wall_count, 0);
        check_value("wall_added", wall_added, 1'b0);

        done = 1'b0;
        while (!done) begin
            r = $fscanf(fd, "%s", cmd);
            if (r != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                r = $fgets(line_buf, fd);
            end else if (cmd == "snake") begin
                r      = $fscanf(fd, "%d %h %d", mode_v, cell_v, n_v);
                body_v = '0;
                for (i = 0; i < n_v; i++) begin
                    r         = $fscanf(fd, "%h", seg_v);
                    body_v[i] = seg_v;
                end
                set_snake(mode_v, cell_v, body_v);
            end else if (cmd == "collide") begin
                pulse_collision();
            end else if (cmd == "idle") begin
                r = $fscanf(fd, "%d %h", n_v, cell_v);
                drive_idle(n_v, cell_v);
            end else if (cmd == "cells") begin
                r = $fscanf(fd, "%d", n_v);
                for (i = 0; i < n_v; i++) begin
                    r = $fscanf(fd, "%h", cell_v);
                    drive_cell(cell_v);
                end
            end else if (cmd == "expect") begin
                r = $fscanf(fd, "%h %d", cell_v, n_v);
                expect_wall(cell_v, n_v);
            end else if (cmd == "fill") begin
                r = $fscanf(fd, "%d %d", n_v, m_v);
                fill_walls(n_v, m_v);
            end else if (cmd == "pairs") begin
                r = $fscanf(fd, "%d %h", n_v, cell_v);
                extra_pairs(n_v, cell_v);
            end else if (cmd == "count") begin
                r = $fscanf(fd, "%d", n_v);
                check_count(n_v);
            end else begin
                abort_run($sformatf("unknown command %0s in the test data", cmd));
            end
        end
        $fclose(fd);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/wall_testdata.txt
# command then values; mode, counts and row in decimal; cells in hex as yx
# snake mode head n body..  collide  idle n cell  cells n cell..  expect cell count  fill n row  pairs n cell  count n
snake 0 55 3 54 53 52
collide
idle 40 44
collide
idle 30 00
cells 6 03 f7 55 54 36 47
expect 36 1
collide
collide
idle 30 00
cells 4 36 5f 53 68
expect 68 2
snake 1 22 2 21 20
collide
collide
idle 30 00
cells 5 33 44 65 36 a2
expect a2 3
snake 2 77 2 76 75
collide
collide
idle 30 00
idle 90 1e
cells 1 d1
expect d1 4
snake 0 88 0
fill 21 11
count 25
pairs 25 99
count 25
idle 100 99

//--- project.f
src/wall_pkg.sv
src/spawn_trigger.sv
src/cell_match.sv
src/candidate_check.sv
src/wall_list.sv
src/wall_spawner.sv
verif/tb_clock_gen.sv
verif/wall_spawner_tb.sv

//--- Bender.yml
package:
  name: wall_spawner

sources:
  - files:
      - src/wall_pkg.sv
      - src/spawn_trigger.sv
      - src/cell_match.sv
      - src/candidate_check.sv
      - src/wall_list.sv
      - src/wall_spawner.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/wall_spawner_tb.sv
